//--- verilog/exec_pkg.sv
package exec_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;

  // Steps of the iterative multiply and divide loop.
  localparam int muldiv_cycles = 32;

  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui = 7'b0110111;
  localparam logic [6:0] opcode_system = 7'b1110011;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt = 7'b0100000;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_sll = 3'b001;
  localparam logic [2:0] funct3_slt = 3'b010;
  localparam logic [2:0] funct3_sltu = 3'b011;
  localparam logic [2:0] funct3_xor = 3'b100;
  localparam logic [2:0] funct3_srl_sra = 3'b101;
  localparam logic [2:0] funct3_or = 3'b110;
  localparam logic [2:0] funct3_and = 3'b111;

  localparam logic [2:0] funct3_mul = 3'b000;
  localparam logic [2:0] funct3_mulhu = 3'b011;
  localparam logic [2:0] funct3_divu = 3'b101;
  localparam logic [2:0] funct3_remu = 3'b111;

  // The only SYSTEM word in the supported subset.
  localparam logic [31:0] ebreak_word = 32'h00100073;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_type;

  typedef enum logic [1:0] {
    md_mul,
    md_mulhu,
    md_divu,
    md_remu
  } muldiv_op_type;

  typedef enum logic [3:0] {
    ecause_illegal = 4'd2,
    ecause_breakpoint = 4'd3
  } ecause_type;

endpackage

//--- verilog/inst_decoder.sv
module inst_decoder (
  input  logic [exec_pkg::xlen-1:0] instr,
  output logic [exec_pkg::reg_addr_w-1:0] raddr1,
  output logic [exec_pkg::reg_addr_w-1:0] raddr2,
  output logic [exec_pkg::reg_addr_w-1:0] waddr,
  output logic rden1,
  output logic rden2,
  output logic [exec_pkg::xlen-1:0] imm,
  output exec_pkg::alu_op_type alu_op,
  output exec_pkg::muldiv_op_type muldiv_op,
  output logic is_alu,
  output logic is_lui,
  output logic is_muldiv,
  output logic is_ebreak,
  output logic legal
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign raddr1 = instr[19:15];
  assign raddr2 = instr[24:20];
  assign waddr = instr[11:7];

  always_comb begin
    rden1 = 1'b0;
    rden2 = 1'b0;
    imm = {{20{instr[31]}}, instr[31:20]};
    alu_op = exec_pkg::alu_add;
    muldiv_op = exec_pkg::md_mul;
    is_alu = 1'b0;
    is_lui = 1'b0;
    is_muldiv = 1'b0;
    is_ebreak = 1'b0;
    legal = 1'b0;

    case (opcode)
      exec_pkg::opcode_op: begin
        rden1 = 1'b1;
        rden2 = 1'b1;
        if (funct7 == exec_pkg::funct7_muldiv) begin
          legal = 1'b1;
          case (funct3)
            exec_pkg::funct3_mul: muldiv_op = exec_pkg::md_mul;
            exec_pkg::funct3_mulhu: muldiv_op = exec_pkg::md_mulhu;
            exec_pkg::funct3_divu: muldiv_op = exec_pkg::md_divu;
            exec_pkg::funct3_remu: muldiv_op = exec_pkg::md_remu;
            default: legal = 1'b0;
          endcase
          is_muldiv = legal;
        end else begin
          case (funct3)
            exec_pkg::funct3_add_sub: begin
              alu_op = (funct7 == exec_pkg::funct7_alt) ? exec_pkg::alu_sub : exec_pkg::alu_add;
            end
            exec_pkg::funct3_sll: alu_op = exec_pkg::alu_sll;
            exec_pkg::funct3_slt: alu_op = exec_pkg::alu_slt;
            exec_pkg::funct3_sltu: alu_op = exec_pkg::alu_sltu;
            exec_pkg::funct3_xor: alu_op = exec_pkg::alu_xor;
            exec_pkg::funct3_srl_sra: begin
              alu_op = (funct7 == exec_pkg::funct7_alt) ? exec_pkg::alu_sra : exec_pkg::alu_srl;
            end
            exec_pkg::funct3_or: alu_op = exec_pkg::alu_or;
            default: alu_op = exec_pkg::alu_and;
          endcase
          // Only SUB and SRA use the alternate funct7.
          legal = (funct7 == exec_pkg::funct7_base) ||
                  (funct7 == exec_pkg::funct7_alt &&
                   (funct3 == exec_pkg::funct3_add_sub || funct3 == exec_pkg::funct3_srl_sra));
          is_alu = legal;
        end
      end
      exec_pkg::opcode_op_imm: begin
        rden1 = 1'b1;
        legal = 1'b1;
        case (funct3)
          exec_pkg::funct3_add_sub: alu_op = exec_pkg::alu_add;
          exec_pkg::funct3_sll: begin
            alu_op = exec_pkg::alu_sll;
            legal = funct7 == exec_pkg::funct7_base;
          end
          exec_pkg::funct3_slt: alu_op = exec_pkg::alu_slt;
          exec_pkg::funct3_sltu: alu_op = exec_pkg::alu_sltu;
          exec_pkg::funct3_xor: alu_op = exec_pkg::alu_xor;
          exec_pkg::funct3_srl_sra: begin
            alu_op = (funct7 == exec_pkg::funct7_alt) ? exec_pkg::alu_sra : exec_pkg::alu_srl;
            legal = funct7 == exec_pkg::funct7_base || funct7 == exec_pkg::funct7_alt;
          end
          exec_pkg::funct3_or: alu_op = exec_pkg::alu_or;
          default: alu_op = exec_pkg::alu_and;
        endcase
        is_alu = legal;
      end
      exec_pkg::opcode_lui: begin
        imm = {instr[31:12], 12'b0};
        is_lui = 1'b1;
        legal = 1'b1;
      end
      exec_pkg::opcode_system: begin
        is_ebreak = instr == exec_pkg::ebreak_word;
        legal = is_ebreak;
      end
      default: legal = 1'b0;
    endcase
  end

endmodule

//--- verilog/int_alu.sv
module int_alu (
  input  logic [exec_pkg::xlen-1:0] a,
  input  logic [exec_pkg::xlen-1:0] b,
  input  exec_pkg::alu_op_type op,
  output logic [exec_pkg::xlen-1:0] res
);

  logic [$clog2(exec_pkg::xlen)-1:0] shamt;
  logic lt_signed;
  logic lt_unsigned;

  // Shift amounts come from the low bits only.
  assign shamt = b[$clog2(exec_pkg::xlen)-1:0];

  assign lt_signed = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (op)
      exec_pkg::alu_add: res = a + b;
      exec_pkg::alu_sub: res = a - b;
      exec_pkg::alu_sll: res = a << shamt;
      exec_pkg::alu_slt: res = {{(exec_pkg::xlen-1){1'b0}}, lt_signed};
      exec_pkg::alu_sltu: res = {{(exec_pkg::xlen-1){1'b0}}, lt_unsigned};
      exec_pkg::alu_xor: res = a ^ b;
      exec_pkg::alu_srl: res = a >> shamt;
      exec_pkg::alu_sra: res = $unsigned($signed(a) >>> shamt);
      exec_pkg::alu_or: res = a | b;
      exec_pkg::alu_and: res = a & b;
      default: res = a + b;
    endcase
  end

endmodule

//--- verilog/muldiv_unit.sv
module muldiv_unit (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  exec_pkg::muldiv_op_type op,
  input  logic [exec_pkg::xlen-1:0] a,
  input  logic [exec_pkg::xlen-1:0] b,
  output logic done,
  output logic [exec_pkg::xlen-1:0] res
);

  logic busy;
  logic [$clog2(exec_pkg::muldiv_cycles)-1:0] cnt;
  exec_pkg::muldiv_op_type op_r;
  // Multiplicand or divisor.
  logic [exec_pkg::xlen-1:0] opnd;
  // High half is the product or remainder, low half the multiplier or quotient.
  logic [2*exec_pkg::xlen-1:0] acc;
  logic [exec_pkg::xlen:0] sum;
  logic [exec_pkg::xlen:0] shifted;
  logic [exec_pkg::xlen:0] diff;
  logic is_div;

  assign is_div = op_r == exec_pkg::md_divu || op_r == exec_pkg::md_remu;

  // One shift-add step and one restoring step, selected below.
  always_comb begin
    sum = {1'b0, acc[2*exec_pkg::xlen-1:exec_pkg::xlen]} +
          (acc[0] ? {1'b0, opnd} : '0);
    shifted = {acc[2*exec_pkg::xlen-1:exec_pkg::xlen], acc[exec_pkg::xlen-1]};
    diff = shifted - {1'b0, opnd};
  end

  assign res = (op_r == exec_pkg::md_mul || op_r == exec_pkg::md_divu) ?
               acc[exec_pkg::xlen-1:0] : acc[2*exec_pkg::xlen-1:exec_pkg::xlen];

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      busy <= 1'b0;
      done <= 1'b0;
      cnt <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy <= 1'b1;
        cnt <= '0;
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        if (cnt == exec_pkg::muldiv_cycles - 1) begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_r <= op;
      opnd <= b;
      acc <= {{exec_pkg::xlen{1'b0}}, a};
    end else if (busy) begin
      if (!is_div) begin
        acc <= {sum, acc[exec_pkg::xlen-1:1]};
      end else if (diff[exec_pkg::xlen]) begin
        acc <= {shifted[exec_pkg::xlen-1:0], acc[exec_pkg::xlen-2:0], 1'b0};
      end else begin
        // A zero divisor always subtracts, so the quotient ends as all ones.
        acc <= {diff[exec_pkg::xlen-1:0], acc[exec_pkg::xlen-2:0], 1'b1};
      end
    end
  end

  // A done pulse always closes a run that started a fixed number of edges earlier.
  a_done_after_run: assert property (@(posedge clk) disable iff (!rst)
    done |-> $past(start, exec_pkg::muldiv_cycles + 1));

  a_start_when_idle: assert property (@(posedge clk) disable iff (!rst)
    start |-> !busy);

endmodule

//--- verilog/register_file.sv
module register_file (
  input  logic clk,
  input  logic rst,
  input  logic [exec_pkg::reg_addr_w-1:0] raddr1,
  input  logic [exec_pkg::reg_addr_w-1:0] raddr2,
  input  logic wr_en,
  input  logic [exec_pkg::reg_addr_w-1:0] wr_addr,
  input  logic [exec_pkg::xlen-1:0] wr_data,
  output logic [exec_pkg::xlen-1:0] rdata1,
  output logic [exec_pkg::xlen-1:0] rdata2
);

  logic [exec_pkg::xlen-1:0] regs [2**exec_pkg::reg_addr_w];

  always_ff @(posedge clk) begin
    if (rst == 0) begin
      for (int i = 0; i < 2**exec_pkg::reg_addr_w; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_addr != '0) begin
      // x0 keeps its reset value.
      regs[wr_addr] <= wr_data;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

//--- verilog/execute_stage.sv
module execute_stage (
  input  logic clk,
  input  logic rst,
  input  logic instr_valid,
  input  logic [exec_pkg::xlen-1:0] instr,
  input  logic [exec_pkg::reg_addr_w-1:0] raddr1,
  input  logic [exec_pkg::reg_addr_w-1:0] raddr2,
  input  logic rden1,
  input  logic rden2,
  input  logic [exec_pkg::reg_addr_w-1:0] waddr,
  input  logic [exec_pkg::xlen-1:0] imm,
  input  exec_pkg::alu_op_type dec_alu_op,
  input  exec_pkg::muldiv_op_type muldiv_op,
  input  logic is_alu,
  input  logic is_lui,
  input  logic is_muldiv,
  input  logic is_ebreak,
  input  logic legal,
  input  logic [exec_pkg::xlen-1:0] rdata1,
  input  logic [exec_pkg::xlen-1:0] rdata2,
  input  logic [exec_pkg::xlen-1:0] alu_res,
  input  logic md_done,
  input  logic [exec_pkg::xlen-1:0] md_res,
  output logic [exec_pkg::xlen-1:0] alu_a,
  output logic [exec_pkg::xlen-1:0] alu_b,
  output exec_pkg::alu_op_type alu_op,
  output logic md_start,
  output exec_pkg::muldiv_op_type md_op,
  output logic [exec_pkg::xlen-1:0] md_a,
  output logic [exec_pkg::xlen-1:0] md_b,
  output logic wr_en,
  output logic [exec_pkg::reg_addr_w-1:0] wr_addr,
  output logic [exec_pkg::xlen-1:0] wr_data,
  output logic stall,
  output logic retire_valid,
  output logic [exec_pkg::reg_addr_w-1:0] retire_waddr,
  output logic [exec_pkg::xlen-1:0] retire_wdata,
  output logic exception,
  output exec_pkg::ecause_type ecause,
  output logic [exec_pkg::xlen-1:0] etval
);

  typedef struct packed {
    logic busy;
    logic md_start;
    exec_pkg::muldiv_op_type md_op;
    logic [exec_pkg::xlen-1:0] md_a;
    logic [exec_pkg::xlen-1:0] md_b;
    logic [exec_pkg::reg_addr_w-1:0] waddr;
    logic retire_valid;
    logic [exec_pkg::reg_addr_w-1:0] retire_waddr;
    logic [exec_pkg::xlen-1:0] retire_wdata;
    logic exception;
    exec_pkg::ecause_type ecause;
    logic [exec_pkg::xlen-1:0] etval;
  } stage_reg_type;

  stage_reg_type r, rin, v;
  logic [exec_pkg::xlen-1:0] op_a;
  logic [exec_pkg::xlen-1:0] op_b;

  always_comb begin
    v = r;
    v.md_start = 1'b0;
    v.retire_valid = 1'b0;
    v.exception = 1'b0;

    // Operands that the instruction does not read are zero.
    op_a = (rden1 && raddr1 != '0) ? rdata1 : '0;
    op_b = (rden2 && raddr2 != '0) ? rdata2 : '0;

    alu_a = op_a;
    alu_b = rden2 ? op_b : imm;
    alu_op = dec_alu_op;

    wr_en = 1'b0;
    wr_addr = waddr;
    wr_data = is_lui ? imm : alu_res;

    if (r.busy) begin
      // Held muldiv instruction; nothing new is taken.
      wr_addr = r.waddr;
      wr_data = md_res;
      if (md_done) begin
        wr_en = 1'b1;
        v.busy = 1'b0;
        v.retire_valid = 1'b1;
        v.retire_waddr = r.waddr;
        v.retire_wdata = md_res;
      end
    end else if (instr_valid) begin
      if (!legal || is_ebreak) begin
        v.exception = 1'b1;
        v.ecause = legal ? exec_pkg::ecause_breakpoint : exec_pkg::ecause_illegal;
        v.etval = instr;
      end else if (is_muldiv) begin
        v.busy = 1'b1;
        v.md_start = 1'b1;
        v.md_op = muldiv_op;
        v.md_a = op_a;
        v.md_b = op_b;
        v.waddr = waddr;
      end else begin
        wr_en = is_alu | is_lui;
        v.retire_valid = 1'b1;
        v.retire_waddr = waddr;
        v.retire_wdata = wr_data;
      end
    end

    rin = v;
  end

  // Stays high through the cycle in which the muldiv result is written.
  assign stall = r.busy;

  assign md_start = r.md_start;
  assign md_op = r.md_op;
  assign md_a = r.md_a;
  assign md_b = r.md_b;

  assign retire_valid = r.retire_valid;
  assign retire_waddr = r.retire_waddr;
  assign retire_wdata = r.retire_wdata;
  assign exception = r.exception;
  assign ecause = r.ecause;
  assign etval = r.etval;

  always_ff @(posedge clk) begin
    r <= rin;
    if (rst == 0) begin
      r.busy <= 1'b0;
      r.md_start <= 1'b0;
      r.retire_valid <= 1'b0;
      r.exception <= 1'b0;
    end
  end

  // A muldiv result only arrives while the stage waits for it.
  a_done_in_stall: assert property (@(posedge clk) disable iff (!rst)
    md_done |-> stall);

  // A stall lasts exactly one muldiv run.
  a_stall_length: assert property (@(posedge clk) disable iff (!rst)
    $rose(stall) |-> ##(exec_pkg::muldiv_cycles + 1) md_done);

endmodule

//--- verilog/execute_top.sv
module execute_top (
  input  logic clk,
  input  logic rst,
  input  logic [exec_pkg::xlen-1:0] instr,
  input  logic instr_valid,
  output logic stall,
  output logic retire_valid,
  output logic [exec_pkg::reg_addr_w-1:0] retire_waddr,
  output logic [exec_pkg::xlen-1:0] retire_wdata,
  output logic exception,
  output exec_pkg::ecause_type ecause,
  output logic [exec_pkg::xlen-1:0] etval
);

  logic [exec_pkg::reg_addr_w-1:0] raddr1;
  logic [exec_pkg::reg_addr_w-1:0] raddr2;
  logic [exec_pkg::reg_addr_w-1:0] waddr;
  logic rden1;
  logic rden2;
  logic [exec_pkg::xlen-1:0] imm;
  exec_pkg::alu_op_type dec_alu_op;
  exec_pkg::muldiv_op_type muldiv_op;
  logic is_alu;
  logic is_lui;
  logic is_muldiv;
  logic is_ebreak;
  logic legal;
  logic [exec_pkg::xlen-1:0] rdata1;
  logic [exec_pkg::xlen-1:0] rdata2;
  logic [exec_pkg::xlen-1:0] alu_a;
  logic [exec_pkg::xlen-1:0] alu_b;
  exec_pkg::alu_op_type alu_op;
  logic [exec_pkg::xlen-1:0] alu_res;
  logic md_start;
  exec_pkg::muldiv_op_type md_op;
  logic [exec_pkg::xlen-1:0] md_a;
  logic [exec_pkg::xlen-1:0] md_b;
  logic md_done;
  logic [exec_pkg::xlen-1:0] md_res;
  logic wr_en;
  logic [exec_pkg::reg_addr_w-1:0] wr_addr;
  logic [exec_pkg::xlen-1:0] wr_data;

  inst_decoder decoder_i (
    .instr(instr), .raddr1(raddr1), .raddr2(raddr2), .waddr(waddr),
    .rden1(rden1), .rden2(rden2), .imm(imm), .alu_op(dec_alu_op),
    .muldiv_op(muldiv_op), .is_alu(is_alu), .is_lui(is_lui),
    .is_muldiv(is_muldiv), .is_ebreak(is_ebreak), .legal(legal)
  );

  register_file regfile_i (
    .clk(clk), .rst(rst), .raddr1(raddr1), .raddr2(raddr2),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rdata1(rdata1), .rdata2(rdata2)
  );

  int_alu alu_i (.a(alu_a), .b(alu_b), .op(alu_op), .res(alu_res));

  muldiv_unit muldiv_i (
    .clk(clk), .rst(rst), .start(md_start), .op(md_op), .a(md_a), .b(md_b),
    .done(md_done), .res(md_res)
  );

  execute_stage stage_i (
    .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr),
    .raddr1(raddr1), .raddr2(raddr2), .rden1(rden1), .rden2(rden2),
    .waddr(waddr), .imm(imm), .dec_alu_op(dec_alu_op), .muldiv_op(muldiv_op),
    .is_alu(is_alu), .is_lui(is_lui), .is_muldiv(is_muldiv),
    .is_ebreak(is_ebreak), .legal(legal), .rdata1(rdata1), .rdata2(rdata2),
    .alu_res(alu_res), .md_done(md_done), .md_res(md_res),
    .alu_a(alu_a), .alu_b(alu_b), .alu_op(alu_op), .md_start(md_start),
    .md_op(md_op), .md_a(md_a), .md_b(md_b), .wr_en(wr_en),
    .wr_addr(wr_addr), .wr_data(wr_data), .stall(stall),
    .retire_valid(retire_valid), .retire_waddr(retire_waddr),
    .retire_wdata(retire_wdata), .exception(exception), .ecause(ecause),
    .etval(etval)
  );

endmodule

//--- test/execute_tb.sv
module execute_tb;

  localparam int clk_period = 20;
  localparam int directed_count = 51;
  localparam int random_count = 400;
  localparam int timeout_time = (directed_count + random_count + 10) *
                                (exec_pkg::muldiv_cycles + 4) * clk_period;

  typedef struct packed {
    logic exc;
    logic [3:0] cause;
    logic [4:0] waddr;
    // Result, or the instruction word on an exception.
    logic [31:0] data;
  } exp_type;

  logic clk;
  logic rst;
  logic [31:0] instr;
  logic instr_valid;
  logic stall;
  logic retire_valid;
  logic [4:0] retire_waddr;
  logic [31:0] retire_wdata;
  logic exception;
  exec_pkg::ecause_type ecause;
  logic [31:0] etval;

  logic [31:0] lfsr_state;
  logic [31:0] model_regs [32];
  exp_type expected [$];

  execute_top dut_i (
    .clk(clk), .rst(rst), .instr(instr), .instr_valid(instr_valid), .stall(stall),
    .retire_valid(retire_valid), .retire_waddr(retire_waddr),
    .retire_wdata(retire_wdata), .exception(exception), .ecause(ecause), .etval(etval)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      abort_run($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, name, got, want));
    end
  endtask

  function automatic logic next_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) lfsr_state = lfsr_state ^ 32'h80200003;
    return out;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v = {v[30:0], next_bit()};
    return v;
  endfunction

  function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [4:0] rs2,
      input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, exec_pkg::opcode_op};
  endfunction

  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
      input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, exec_pkg::opcode_op_imm};
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
      input logic [31:0] a, input logic [31:0] b);
    case (f3)
      3'b000: return alt ? a - b : a + b;
      3'b001: return a << b[4:0];
      3'b010: return {31'b0, $signed(a) < $signed(b)};
      3'b011: return {31'b0, a < b};
      3'b100: return a ^ b;
      3'b101: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110: return a | b;
      default: return a & b;
    endcase
  endfunction

  // Expected outcome of one instruction against the model registers.
  function automatic exp_type predict(input logic [31:0] word);
    logic [6:0] f7;
    logic [2:0] f3;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [63:0] prod;
    logic bad;
    exp_type e;
    f7 = word[31:25];
    f3 = word[14:12];
    a = model_regs[word[19:15]];
    b = model_regs[word[24:20]];
    imm = {{20{word[31]}}, word[31:20]};
    prod = {32'b0, a} * {32'b0, b};
    bad = 1'b0;
    e.exc = 1'b0;
    e.cause = 4'd0;
    e.waddr = word[11:7];
    e.data = '0;
    case (word[6:0])
      exec_pkg::opcode_op: begin
        if (f7 == exec_pkg::funct7_muldiv) begin
          case (f3)
            3'b000: e.data = prod[31:0];
            3'b011: e.data = prod[63:32];
            3'b101: e.data = (b == 0) ? '1 : a / b;
            3'b111: e.data = (b == 0) ? a : a % b;
            default: bad = 1'b1;
          endcase
        end else if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101))) begin
          e.data = alu_model(f3, f7[5], a, b);
        end else begin
          bad = 1'b1;
        end
      end
      exec_pkg::opcode_op_imm: begin
        if (f3 == 3'b001 && f7 != 7'h00) bad = 1'b1;
        else if (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20) bad = 1'b1;
        else e.data = alu_model(f3, f3 == 3'b101 && f7[5], a, imm);
      end
      exec_pkg::opcode_lui: e.data = {word[31:12], 12'b0};
      exec_pkg::opcode_system: begin
        if (word == exec_pkg::ebreak_word) begin
          e.exc = 1'b1;
          e.cause = 4'd3;
        end else begin
          bad = 1'b1;
        end
      end
      default: bad = 1'b1;
    endcase
    if (bad) begin
      e.exc = 1'b1;
      e.cause = 4'd2;
    end
    if (e.exc) e.data = word;
    return e;
  endfunction

  // Registers x0 to x7 only, so that dependent pairs come often.
  function automatic logic [31:0] make_instr();
    logic [3:0] kind;
    logic [2:0] f3;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [6:0] f7;
    logic [11:0] imm;
    kind = 4'(random_bits(4));
    f3 = 3'(random_bits(3));
    rd = 5'(random_bits(3));
    rs1 = 5'(random_bits(3));
    rs2 = 5'(random_bits(3));
    f7 = next_bit() ? 7'h20 : 7'h00;
    imm = 12'(random_bits(12));
    if (kind <= 4'd5) begin
      if (f3 != 3'b000 && f3 != 3'b101) f7 = 7'h00;
      return encode_r(f7, rs2, rs1, f3, rd);
    end else if (kind <= 4'd8) begin
      if (f3 == 3'b001) imm[11:5] = 7'h00;
      if (f3 == 3'b101) imm[11:5] = f7;
      return encode_i(imm, rs1, f3, rd);
    end else if (kind == 4'd9) begin
      return {20'(random_bits(20)), rd, exec_pkg::opcode_lui};
    end else if (kind <= 4'd12) begin
      f3 = {f3[1], f3[0], f3[1:0] != 2'b00};
      return encode_r(exec_pkg::funct7_muldiv, rs2, rs1, f3, rd);
    end else if (kind == 4'd13) begin
      return exec_pkg::ebreak_word;
    end
    return random_bits(32);
  endfunction

  task automatic send(input logic [31:0] word);
    exp_type e;
    e = predict(word);
    if (!e.exc && e.waddr != 5'd0) model_regs[e.waddr] = e.data;
    expected.push_back(e);
    instr <= word;
    instr_valid <= 1'b1;
    @(posedge clk);
    while (stall) @(posedge clk);
  endtask

  task automatic run_directed();
    // Every register reads as zero after reset.
    for (int i = 0; i < 32; i++) send(encode_i(12'd0, 5'(i), 3'b000, 5'(i)));
    send({20'h12345, 5'd1, exec_pkg::opcode_lui});
    send(encode_i(12'h678, 5'd1, 3'b000, 5'd1));
    send(encode_r(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
    send(encode_r(7'h20, 5'd1, 5'd2, 3'b000, 5'd3));
    send(encode_i(12'hfff, 5'd0, 3'b000, 5'd5));
    send(encode_r(7'h20, 5'd1, 5'd5, 3'b101, 5'd6));
    send(encode_r(7'h00, 5'd5, 5'd1, 3'b011, 5'd7));
    send(encode_r(exec_pkg::funct7_muldiv, 5'd5, 5'd1, 3'b000, 5'd8));
    send(encode_r(exec_pkg::funct7_muldiv, 5'd5, 5'd1, 3'b011, 5'd9));
    send(encode_r(exec_pkg::funct7_muldiv, 5'd1, 5'd5, 3'b101, 5'd10));
    send(encode_r(exec_pkg::funct7_muldiv, 5'd1, 5'd5, 3'b111, 5'd11));
    send(encode_r(exec_pkg::funct7_muldiv, 5'd0, 5'd1, 3'b101, 5'd12));
    send(encode_r(exec_pkg::funct7_muldiv, 5'd0, 5'd1, 3'b111, 5'd13));
    send(encode_i(12'd5, 5'd1, 3'b000, 5'd0));
    send(encode_r(7'h00, 5'd0, 5'd0, 3'b000, 5'd14));
    send(exec_pkg::ebreak_word);
    send(32'hffffffff);
    send(encode_r(exec_pkg::funct7_muldiv, 5'd2, 5'd1, 3'b001, 5'd4));
    send(encode_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd15));
  endtask

  always @(posedge clk) begin : compare
    exp_type e;
    if (rst && (retire_valid || exception)) begin
      if (stall) abort_run("Retire or exception event seen while the stage stalls.");
      if (expected.size() == 0) abort_run("Retire or exception event with nothing outstanding.");
      e = expected.pop_front();
      check_value("exception", 32'(exception), 32'(e.exc));
      check_value("retire_valid", 32'(retire_valid), 32'(!e.exc));
      if (e.exc) begin
        check_value("ecause", 32'(ecause), 32'(e.cause));
        check_value("etval", etval, e.data);
      end else begin
        check_value("retire_waddr", 32'(retire_waddr), 32'(e.waddr));
        check_value("retire_wdata", retire_wdata, e.data);
      end
    end
  end

  initial begin
    #(timeout_time);
    abort_run("Watchdog expired before all instructions retired.");
  end

  initial begin
    rst = 1'b0;
    instr = '0;
    instr_valid = 1'b0;
    lfsr_state = 32'd34;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b1;
    repeat (4) begin
      @(posedge clk);
      check_value("stall", 32'(stall), 32'd0);
    end
    run_directed();
    for (int n = 0; n < random_count; n++) send(make_instr());
    instr_valid <= 1'b0;
    while (expected.size() != 0) @(posedge clk);
    // A few idle cycles to catch extra events.
    repeat (4) @(posedge clk);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- project.f
verilog/exec_pkg.sv
verilog/inst_decoder.sv
verilog/int_alu.sv
verilog/muldiv_unit.sv
verilog/register_file.sv
verilog/execute_stage.sv
verilog/execute_top.sv
test/execute_tb.sv

//--- Makefile
TOP = execute_tb

sim:
	verilator --binary --timing --assert -Wno-fatal -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
